/* rtl/coder_macros.svh */
`ifndef CODER_MACROS_SVH
`define CODER_MACROS_SVH

// Packed output word
`define CODE_W 32
// Bit count wide enough for 0 to 32
`define LEN_W 6
`define CAT_W 4
`define VLI_W 11
// Entries in the luminance DC table
`define DC_CATS 12

`endif

/* rtl/codePkg.sv */
`include "coder_macros.svh"

package codePkg;

  // One output or working word
  typedef logic [`CODE_W-1:0] word_t;

  // Number of valid bits in a code or word
  typedef logic [`LEN_W-1:0] len_t;

  // DC size category from 0 to 11
  typedef logic [`CAT_W-1:0] cat_t;

  // Right-aligned VLI bits
  typedef logic [`VLI_W-1:0] vli_t;

endpackage

/* rtl/busPkg.sv */
package busPkg;
  import codePkg::*;

  typedef struct packed {
    logic valid;
    logic last;
    cat_t cat;
    vli_t vli;
  } symbol_t;

  // Code is left-aligned in the word
  typedef struct packed {
    logic  valid;
    logic  last;
    word_t code;
    len_t  len;
  } code_t;

  typedef struct packed {
    logic  valid;
    logic  last;
    logic  wrap;
    word_t upper;
    word_t lower;
    len_t  flushLen;
  } split_t;

  typedef struct packed {
    logic  valid;
    logic  last;
    word_t word;
    len_t  len;
  } wordOut_t;

  typedef enum logic [1:0] {normal, flush, flushWrap} emitState_t;

endpackage

/* rtl/dcHuffmanRom.sv */
`timescale 1ns/1ps
`include "coder_macros.svh"

module dcHuffmanRom (
  input  logic            clk,
  input  busPkg::symbol_t symbol,
  output codePkg::word_t  code,
  output codePkg::len_t   len
);
  import codePkg::*;

  // Standard luminance DC table with right-aligned codes
  localparam word_t codeTable [`DC_CATS] = '{
    'b00,
    'b010,
    'b011,
    'b100,
    'b101,
    'b110,
    'b1110,
    'b11110,
    'b111110,
    'b1111110,
    'b11111110,
    'b111111110
  };

  localparam len_t lenTable [`DC_CATS] = '{
    6'd2, 6'd3, 6'd3, 6'd3, 6'd3, 6'd3,
    6'd4, 6'd5, 6'd6, 6'd7, 6'd8, 6'd9
  };

  always_ff @(posedge clk) begin
    if (symbol.valid) begin
      code <= codeTable[symbol.cat];
      len  <= lenTable[symbol.cat];
    end
  end

endmodule

/* rtl/codeAssembler.sv */
`timescale 1ns/1ps
`include "coder_macros.svh"

module codeAssembler (
  input  logic            clk,
  input  logic            rst_n,
  input  busPkg::symbol_t symbol,
  output busPkg::code_t   code
);
  import codePkg::*;
  import busPkg::*;

  word_t   romCode;
  len_t    romLen;
  symbol_t symbolQ;
  code_t   merged;
  word_t   vliMask;

  dcHuffmanRom huffmanRom (
    .clk    (clk),
    .symbol (symbol),
    .code   (romCode),
    .len    (romLen)
  );

  // Symbol waits beside the table read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      symbolQ.valid <= 1'b0;
      symbolQ.last  <= 1'b0;
    end else begin
      symbolQ <= symbol;
    end
  end

  // Only the low cat bits of the VLI field belong to the symbol
  assign vliMask = ~({`CODE_W{1'b1}} << symbolQ.cat);

  // VLI bits go below the Huffman code
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      merged.valid <= 1'b0;
      merged.last  <= 1'b0;
    end else begin
      merged.valid <= symbolQ.valid;
      merged.last  <= symbolQ.valid & symbolQ.last;
      if (symbolQ.valid) begin
        merged.code <= (romCode << symbolQ.cat) | (word_t'(symbolQ.vli) & vliMask);
        merged.len  <= romLen + len_t'(symbolQ.cat);
      end
    end
  end

  // Left-align so the first bit sits at the word MSB
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      code.valid <= 1'b0;
      code.last  <= 1'b0;
    end else begin
      code.valid <= merged.valid;
      code.last  <= merged.last;
      if (merged.valid) begin
        code.code <= merged.code << (len_t'(`CODE_W) - merged.len);
        code.len  <= merged.len;
      end
    end
  end

endmodule

/* rtl/bitShifter.sv */
`timescale 1ns/1ps
`include "coder_macros.svh"

module bitShifter (
  input  logic           clk,
  input  logic           rst_n,
  input  busPkg::code_t  code,
  output busPkg::split_t split
);
  import codePkg::*;

  len_t fill;
  len_t sum;
  len_t tailLen;
  len_t nextFill;
  logic wrap;

  always_comb begin
    sum = fill + code.len;
    // A block ending exactly on a word boundary flushes as one full word
    if (code.last) begin
      wrap = sum > len_t'(`CODE_W);
    end else begin
      wrap = sum >= len_t'(`CODE_W);
    end
    tailLen  = wrap ? sum - len_t'(`CODE_W) : sum;
    nextFill = code.last ? '0 : tailLen;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill        <= '0;
      split.valid <= 1'b0;
      split.last  <= 1'b0;
      split.wrap  <= 1'b0;
    end else begin
      split.valid <= code.valid;
      split.last  <= code.valid & code.last;
      split.wrap  <= code.valid & wrap;
      if (code.valid) begin
        fill <= nextFill;
        // Bits past the current word spill into lower
        {split.upper, split.lower} <= {code.code, word_t'(0)} >> fill;
        split.flushLen <= tailLen;
      end
    end
  end

endmodule

/* rtl/wordEmitter.sv */
`timescale 1ns/1ps
`include "coder_macros.svh"

module wordEmitter (
  input  logic             clk,
  input  logic             rst_n,
  input  busPkg::split_t   split,
  output busPkg::wordOut_t word
);
  import codePkg::*;
  import busPkg::*;

  emitState_t state;
  emitState_t stateNext;
  word_t      pending;
  word_t      pendingNext;
  word_t      splice;
  len_t       finalLen;
  wordOut_t   wordNext;

  always_comb begin
    splice      = pending | split.upper;
    stateNext   = state;
    pendingNext = pending;
    wordNext       = word;
    wordNext.valid = 1'b0;
    wordNext.last  = 1'b0;

    case (state)
      normal: begin
        if (split.valid) begin
          pendingNext = splice;
          if (split.wrap) begin
            wordNext.valid = 1'b1;
            wordNext.word  = splice;
            wordNext.len   = len_t'(`CODE_W);
            pendingNext    = split.lower;
          end
          if (split.last) begin
            stateNext = split.wrap ? flushWrap : flush;
          end
        end
      end
      // After a wrap the held bits are the spilled remainder
      flush, flushWrap: begin
        wordNext.valid = 1'b1;
        wordNext.last  = 1'b1;
        wordNext.word  = pending;
        wordNext.len   = finalLen;
        pendingNext    = '0;
        stateNext      = normal;
      end
      default: begin
        stateNext   = normal;
        pendingNext = '0;
      end
    endcase
  end

  // Pending bits wait here until a word fills
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= normal;
      pending    <= '0;
      word.valid <= 1'b0;
      word.last  <= 1'b0;
    end else begin
      state   <= stateNext;
      pending <= pendingNext;
      word    <= wordNext;
    end
  end

  always_ff @(posedge clk) begin
    if (split.valid && split.last) begin
      finalLen <= split.flushLen;
    end
  end

endmodule

/* rtl/entropyCoder.sv */
`timescale 1ns/1ps

module entropyCoder (
  input  logic             clk,
  input  logic             rst_n,
  input  busPkg::symbol_t  symbol,
  output busPkg::wordOut_t word
);
  import busPkg::*;

  code_t  codeBus;
  split_t splitBus;

  // Table lookup, merge and align
  codeAssembler assembler (
    .clk    (clk),
    .rst_n  (rst_n),
    .symbol (symbol),
    .code   (codeBus)
  );

  bitShifter shifter (
    .clk   (clk),
    .rst_n (rst_n),
    .code  (codeBus),
    .split (splitBus)
  );

  // Full words and block flush
  wordEmitter emitter (
    .clk   (clk),
    .rst_n (rst_n),
    .split (splitBus),
    .word  (word)
  );

endmodule

/* sim/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rst_n
);
  localparam int halfPeriod  = 10;
  localparam int resetCycles = 2;

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* sim/entropyCoder_checker.sv */
`timescale 1ns/1ps
`include "coder_macros.svh"

module entropyCoder_checker (
  input logic             clk,
  input logic             rst_n,
  input busPkg::wordOut_t word
);
  import codePkg::*;

  // Output stays quiet while reset is held
  validInReset: assert property (
    @(posedge clk) !rst_n |-> !word.valid
  ) else $error("Output word valid while reset is asserted");

  fullWordLen: assert property (
    @(posedge clk) disable iff (!rst_n)
    (word.valid && !word.last) |-> (word.len == len_t'(`CODE_W))
  ) else $error("Full output word carries length %0d", word.len);

  // The flush word holds between 1 and 32 bits
  lastWordLen: assert property (
    @(posedge clk) disable iff (!rst_n)
    (word.valid && word.last) |->
      (word.len >= len_t'(1) && word.len <= len_t'(`CODE_W))
  ) else $error("Block end word carries length %0d", word.len);

endmodule

/* sim/tbEntropyCoder.sv */
`timescale 1ns/1ps
`include "coder_macros.svh"

module tbEntropyCoder;
  import codePkg::*;
  import busPkg::*;

  // Luminance DC table with right-aligned codes
  localparam logic [8:0] dcCode [0:`DC_CATS-1] = '{
    9'h000, 9'h002, 9'h003, 9'h004, 9'h005, 9'h006,
    9'h00e, 9'h01e, 9'h03e, 9'h07e, 9'h0fe, 9'h1fe
  };
  localparam int dcLen [0:`DC_CATS-1] = '{2, 3, 3, 3, 3, 3, 4, 5, 6, 7, 8, 9};

  logic     clk;
  logic     rst_n;
  symbol_t  symbolIn;
  wordOut_t outWord;

  integer   seed;
  int       cycleCount;
  int       cycleLimit;
  int       checkedWords;
  int       valueErrors;
  int       extraWords;
  int       missingWords;

  cat_t     stimCat[$];
  vli_t     stimVli[$];
  logic     stimLast[$];
  bit       bitQ[$];
  wordOut_t expQ[$];

  clockGen clocks (
    .clk   (clk),
    .rst_n (rst_n)
  );

  entropyCoder i_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .symbol (symbolIn),
    .word   (outWord)
  );

  bind entropyCoder entropyCoder_checker outputChecks (
    .clk   (clk),
    .rst_n (rst_n),
    .word  (word)
  );

  function automatic vli_t randomVli(input cat_t cat);
    vli_t mask;
    mask = vli_t'((1 << cat) - 1);
    return vli_t'($random(seed)) & mask;
  endfunction

  // Takes the oldest n bits of the stream MSB first and zero fills the rest
  function automatic wordOut_t packWord(input int n, input logic last);
    wordOut_t w;
    int i;
    w.valid = 1'b1;
    w.last  = last;
    w.len   = len_t'(n);
    w.word  = '0;
    for (i = 0; i < n; i++) begin
      w.word[`CODE_W-1-i] = bitQ.pop_front();
    end
    return w;
  endfunction

  // Appends the Huffman code and VLI bits and cuts full words from the stream
  function automatic void appendSymbol(input cat_t cat, input vli_t vli, input logic last);
    int n;
    for (n = dcLen[cat] - 1; n >= 0; n--) begin
      bitQ.push_back(dcCode[cat][n]);
    end
    for (n = int'(cat) - 1; n >= 0; n--) begin
      bitQ.push_back(vli[n]);
    end
    // A block that fills its word exactly ends with a full word marked last
    while (bitQ.size() > `CODE_W || (!last && bitQ.size() == `CODE_W)) begin
      expQ.push_back(packWord(`CODE_W, 1'b0));
    end
    if (last) begin
      expQ.push_back(packWord(bitQ.size(), 1'b1));
    end
  endfunction

  task automatic addSymbol(input cat_t cat, input logic last);
    stimCat.push_back(cat);
    stimVli.push_back(randomVli(cat));
    stimLast.push_back(last);
  endtask

  task automatic addRandomBlock(input int count, input int minCat);
    int i;
    cat_t cat;
    for (i = 0; i < count; i++) begin
      cat = cat_t'(minCat + {$random(seed)} % (`DC_CATS - minCat));
      addSymbol(cat, i == count - 1);
    end
  endtask

  task automatic buildTests();
    int c;
    int b;
    for (c = 0; c < `DC_CATS; c++) begin
      addSymbol(cat_t'(c), 1'b1);
    end
    // Long codes fill a word every few symbols
    addRandomBlock(16, 4);
    // Two 20-bit codes where the last one wraps
    addSymbol(4'd11, 1'b0);
    addSymbol(4'd11, 1'b1);
    // Codes of 20, 8 and 4 bits fill one word exactly
    addSymbol(4'd11, 1'b0);
    addSymbol(4'd5, 1'b0);
    addSymbol(4'd1, 1'b1);
    // Three 20-bit codes and a 4-bit one fill two words exactly
    addSymbol(4'd11, 1'b0);
    addSymbol(4'd11, 1'b0);
    addSymbol(4'd11, 1'b0);
    addSymbol(4'd1, 1'b1);
    for (b = 0; b < 8; b++) begin
      addRandomBlock(1 + {$random(seed)} % 6, 0);
    end
  endtask

  task automatic driveSymbol(input int idx);
    @(negedge clk);
    symbolIn.valid = 1'b1;
    symbolIn.last  = stimLast[idx];
    symbolIn.cat   = stimCat[idx];
    symbolIn.vli   = stimVli[idx];
    appendSymbol(stimCat[idx], stimVli[idx], stimLast[idx]);
    // Two idle cycles after every block end
    if (stimLast[idx]) begin
      @(negedge clk);
      symbolIn = '0;
      @(negedge clk);
    end
  endtask

  task automatic printSummary();
    $display("Summary: %0d words checked, %0d value errors, %0d extra words, %0d missing words",
             checkedWords, valueErrors, extraWords, missingWords);
  endtask

  initial begin : stimulus
    int i;
    seed         = 75;
    symbolIn     = '0;
    checkedWords = 0;
    valueErrors  = 0;
    extraWords   = 0;
    missingWords = 0;
    buildTests();
    cycleLimit = stimCat.size() * 4 + 50;
    wait (rst_n === 1'b1);
    repeat (3) @(negedge clk);
    for (i = 0; i < stimCat.size(); i++) begin
      driveSymbol(i);
    end
    while (expQ.size() != 0) begin
      @(negedge clk);
    end
    // Room for any stray word after the last block
    repeat (4) @(negedge clk);
    printSummary();
    if (valueErrors == 0 && extraWords == 0 && missingWords == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin : watchdog
    cycleCount = 0;
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    missingWords = expQ.size();
    $display("Timeout after %0d cycles, %0d expected words never came out",
             cycleCount, missingWords);
    printSummary();
    $display("ERRORS FOUND");
    $finish;
  end

  // Outputs change on the rising edge and are sampled on the falling one
  always @(negedge clk) begin : compare
    wordOut_t expected;
    if (outWord.valid === 1'b1) begin
      if (expQ.size() == 0) begin
        extraWords++;
        $display("Extra output word %h at time %0t when no word was expected",
                 outWord.word, $time);
      end else begin
        expected = expQ.pop_front();
        checkedWords++;
        if (outWord.word !== expected.word) begin
          valueErrors++;
          $display("ERR %0t: word %0d data %h, expected %h",
                   $time, checkedWords, outWord.word, expected.word);
        end
        if (outWord.len !== expected.len) begin
          valueErrors++;
          $display("ERR %0t: word %0d len %0d, expected %0d",
                   $time, checkedWords, outWord.len, expected.len);
        end
        if (outWord.last !== expected.last) begin
          valueErrors++;
          $display("ERR %0t: word %0d last %b, expected %b",
                   $time, checkedWords, outWord.last, expected.last);
        end
      end
    end
  end

endmodule

/* verilog.f */
+incdir+rtl
rtl/codePkg.sv
rtl/busPkg.sv
rtl/dcHuffmanRom.sv
rtl/codeAssembler.sv
rtl/bitShifter.sv
rtl/wordEmitter.sv
rtl/entropyCoder.sv
sim/clockGen.sv
sim/entropyCoder_checker.sv
sim/tbEntropyCoder.sv
